// File: files.f
logic/cache_pkg.sv
logic/cache_req_queue.sv
logic/cache_line_store.sv
logic/direct_cache.sv
logic/data_memory.sv
logic/cache_subsystem.sv
verif/cache_tb.sv

// File: verif/cache_cases.txt
# test op(0 read, 1 write, 2 reset) addr wdata exp_rdata exp_hit gap
# addr and data in hex; gap 1 allows a random idle gap before the issue, gap 0 issues at once
1 1 0010 11110010 11110010 0 1
1 0 0010 00000000 11110010 1 1
2 1 0004 22220004 22220004 0 1
2 1 0104 22220104 22220104 0 1
2 0 0004 00000000 22220004 0 1
2 0 0104 00000000 22220104 0 1
3 1 0008 33330008 33330008 0 1
3 1 0028 33330028 33330028 0 1
3 0 0008 00000000 33330008 0 1
3 0 0028 00000000 33330028 0 1
3 0 0008 00000000 33330008 0 1
3 0 000b 00000000 33330008 1 1
4 1 000c 4444000c 4444000c 0 0
4 1 0014 44440014 44440014 0 0
4 0 000c 00000000 4444000c 1 0
4 0 0014 00000000 44440014 1 0
4 1 002c 4444002c 4444002c 0 0
4 0 000c 00000000 4444000c 0 0
4 1 0018 44440018 44440018 0 0
4 1 0018 44441018 44441018 1 0
5 1 001c 5555001c 5555001c 0 1
5 1 003c 5555003c 5555003c 0 1
5 0 001c 00000000 5555001c 0 1
5 1 001c 5555a01c 5555a01c 1 1
5 2 0000 00000000 00000000 0 0
5 0 001c 00000000 5555001c 0 1
5 0 003c 00000000 5555003c 0 1
5 0 0008 00000000 33330008 0 1
5 0 0004 00000000 22220004 0 1

// File: verif/cache_tb.sv
// cache testbench with case-file driver, credit tracking, tag model and in-order response checks
`timescale 1ns/1ps

module cache_tb;

    logic                               clk_i;
    logic                               rst_i;
    logic                               req_valid_i;
    cache_pkg::cache_op_e               req_op_i;
    logic [cache_pkg::ADDR_WIDTH-1:0]   req_addr_i;
    logic [cache_pkg::DATA_WIDTH-1:0]   req_wdata_i;
    logic                               req_credit_o;
    logic                               resp_valid_o;
    logic [cache_pkg::DATA_WIDTH-1:0]   resp_rdata_o;
    logic                               resp_hit_o;

    integer credits;
    integer errors;
    integer checks;
    integer tests_run;
    integer tests_failed;
    integer test_errs_start;
    integer test_reqs;
    integer cur_test;
    bit     timed_out;

    // responses in arrival order and expectations in issue order
    logic [cache_pkg::DATA_WIDTH-1:0] resp_data_q [$];
    logic                             resp_hit_q  [$];
    logic [cache_pkg::DATA_WIDTH-1:0] exp_data_q  [$];
    logic                             exp_hit_q   [$];
    integer                           exp_line_q  [$];

    // reference model of the lines and the backing words
    logic [cache_pkg::TAG_WIDTH-1:0]  m_tag  [cache_pkg::NUM_SETS];
    logic [cache_pkg::DATA_WIDTH-1:0] m_data [cache_pkg::NUM_SETS];
    logic [cache_pkg::NUM_SETS-1:0]   m_valid;
    logic [cache_pkg::NUM_SETS-1:0]   m_dirty;
    logic [cache_pkg::DATA_WIDTH-1:0] m_mem  [cache_pkg::MEM_WORDS];  // x until written back

    cache_subsystem dut0 (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_valid_i  (req_valid_i),
        .req_op_i     (req_op_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .req_credit_o (req_credit_o),
        .resp_valid_o (resp_valid_o),
        .resp_rdata_o (resp_rdata_o),
        .resp_hit_o   (resp_hit_o)
    );

    always #2 clk_i = ~clk_i;

    // credits held by the requester and spent one per valid cycle
    always @(posedge clk_i) begin
        if (rst_i) begin
            credits = cache_pkg::REQ_QUEUE_DEPTH;
        end else begin
            credits = credits + (req_credit_o ? 1 : 0) - (req_valid_i ? 1 : 0);
            if (credits > cache_pkg::REQ_QUEUE_DEPTH || credits < 0) begin
                errors++;
                $display("credit count out of range at %0t: %0d held", $time, credits);
            end
        end
    end

    always @(posedge clk_i) begin
        if (!rst_i && resp_valid_o) begin
            resp_data_q.push_back(resp_rdata_o);
            resp_hit_q.push_back(resp_hit_o);
        end
    end

    task automatic check_data(input string name, input logic [cache_pkg::DATA_WIDTH-1:0] exp,
                              input logic [cache_pkg::DATA_WIDTH-1:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_hit(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED at %0t: %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_credits(input string name, input integer exp, input integer act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("FAILED at %0t: %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic model_reset();
        m_valid = '0;
        m_dirty = '0;
    endtask

    // direct mapped write-back cache that allocates writes without a fill
    task automatic model_access(input integer op, input logic [cache_pkg::ADDR_WIDTH-1:0] addr,
                                input logic [cache_pkg::DATA_WIDTH-1:0] wdata,
                                output logic [cache_pkg::DATA_WIDTH-1:0] data, output logic hit);
        logic [cache_pkg::SET_WIDTH-1:0] set;
        logic [cache_pkg::TAG_WIDTH-1:0] tag;
        set = addr[cache_pkg::OFFSET_WIDTH +: cache_pkg::SET_WIDTH];
        tag = addr[cache_pkg::ADDR_WIDTH-1 -: cache_pkg::TAG_WIDTH];
        hit = m_valid[set] && (m_tag[set] == tag);
        if (!hit && m_valid[set] && m_dirty[set]) begin
            m_mem[{m_tag[set], set}] = m_data[set];  // victim goes back
        end
        if (!hit) begin
            m_tag[set]   = tag;
            m_valid[set] = 1'b1;
            m_dirty[set] = 1'b0;
            m_data[set]  = m_mem[{tag, set}];
        end
        if (op == 1) begin
            m_data[set]  = wdata;
            m_dirty[set] = 1'b1;
        end
        data = m_data[set];
    endtask

    task automatic issue_request(input integer op, input logic [cache_pkg::ADDR_WIDTH-1:0] addr,
                                 input logic [cache_pkg::DATA_WIDTH-1:0] wdata);
        integer waited;
        waited = 0;
        while (credits == 0 && waited < 200) begin
            @(posedge clk_i);
            #1;
            waited++;
        end
        if (credits == 0) begin
            timed_out = 1'b1;
            errors++;
            $display("timeout: no credit came back within 200 cycles");
        end else begin
            req_valid_i = 1'b1;
            req_op_i    = (op == 1) ? cache_pkg::OP_WRITE : cache_pkg::OP_READ;
            req_addr_i  = addr;
            req_wdata_i = wdata;
            @(posedge clk_i);
            #1;
            req_valid_i = 1'b0;
        end
    endtask

    task automatic drain_responses();
        integer waited;
        integer line;
        while (exp_data_q.size() > 0 && !timed_out) begin
            waited = 0;
            while (resp_data_q.size() == 0 && waited < 200) begin
                @(posedge clk_i);
                #1;
                waited++;
            end
            line = exp_line_q.pop_front();
            if (resp_data_q.size() == 0) begin
                timed_out = 1'b1;
                errors++;
                $display("timeout: no response within 200 cycles for case line %0d", line);
            end else begin
                check_data($sformatf("resp_rdata_o (case line %0d)", line),
                           exp_data_q.pop_front(), resp_data_q.pop_front());
                check_hit($sformatf("resp_hit_o (case line %0d)", line),
                          exp_hit_q.pop_front(), resp_hit_q.pop_front());
            end
        end
    endtask

    task automatic apply_reset();
        req_valid_i = 1'b0;
        rst_i       = 1'b1;
        repeat (5) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        model_reset();  // memory keeps its words
    endtask

    task automatic close_test();
        drain_responses();
        if (!timed_out) begin
            check_credits("held credits after drain", cache_pkg::REQ_QUEUE_DEPTH, credits);
        end
        tests_run++;
        if (errors != test_errs_start) begin
            tests_failed++;
            $display("test %0d: %0d requests, %0d errors", cur_test, test_reqs,
                     errors - test_errs_start);
        end else begin
            $display("test %0d: %0d requests, ok", cur_test, test_reqs);
        end
    endtask

    initial begin
        integer fd;
        integer n;
        integer line_no;
        integer test_id;
        integer op;
        integer exp_hit;
        integer gap;
        logic [cache_pkg::ADDR_WIDTH-1:0] addr;
        logic [cache_pkg::DATA_WIDTH-1:0] wdata;
        logic [cache_pkg::DATA_WIDTH-1:0] exp_data;
        logic [cache_pkg::DATA_WIDTH-1:0] m_rdata;
        logic                             m_hit;
        string                            line_str;

        void'($urandom(32'h230f));
        clk_i        = 1'b0;
        rst_i        = 1'b1;
        req_valid_i  = 1'b0;
        req_op_i     = cache_pkg::OP_READ;
        req_addr_i   = '0;
        req_wdata_i  = '0;
        credits      = cache_pkg::REQ_QUEUE_DEPTH;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cur_test     = -1;
        line_no      = 0;
        timed_out    = 1'b0;
        apply_reset();

        fd = $fopen("verif/cache_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open verif/cache_cases.txt");
        end
        while (fd != 0 && !timed_out && !$feof(fd)) begin
            if ($fgets(line_str, fd) == 0) begin
                break;
            end
            line_no++;
            n = $sscanf(line_str, "%d %d %h %h %h %d %d", test_id, op, addr, wdata,
                        exp_data, exp_hit, gap);
            if (n != 7) begin
                if (line_str.len() > 1 && line_str.getc(0) != "#") begin
                    errors++;
                    $display("case line %0d could not be parsed", line_no);
                end
                continue;
            end
            if (test_id != cur_test) begin
                if (cur_test >= 0) begin
                    close_test();
                end
                cur_test        = test_id;
                test_reqs       = 0;
                test_errs_start = errors;
            end
            if (op == 2) begin
                drain_responses();  // nothing in flight across the reset
                if (!timed_out) begin
                    apply_reset();
                end
            end else begin
                model_access(op, addr, wdata, m_rdata, m_hit);
                if (m_rdata !== exp_data || m_hit !== exp_hit[0]) begin
                    errors++;
                    $display("case line %0d: tag model gives %h hit %b, case file gives %h hit %0d",
                             line_no, m_rdata, m_hit, exp_data, exp_hit);
                end
                exp_data_q.push_back(exp_data);
                exp_hit_q.push_back(exp_hit[0]);
                exp_line_q.push_back(line_no);
                if (gap != 0) begin
                    repeat ($urandom % 4) begin
                        @(posedge clk_i);
                        #1;
                    end
                end
                issue_request(op, addr, wdata);
                test_reqs++;
            end
        end
        if (cur_test >= 0) begin
            close_test();
        end
        if (!timed_out) begin
            repeat (10) @(posedge clk_i);
            #1;
            if (resp_data_q.size() != 0) begin
                errors++;
                $display("%0d responses arrived without a request", resp_data_q.size());
            end
        end

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
                 checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: logic/cache_subsystem.sv
// cache subsystem top: request queue, line store, controller and backing memory
`timescale 1ns/1ps

module cache_subsystem (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                req_valid_i,
    input  cache_pkg::cache_op_e                req_op_i,
    input  logic [cache_pkg::ADDR_WIDTH-1:0]    req_addr_i,
    input  logic [cache_pkg::DATA_WIDTH-1:0]    req_wdata_i,
    output logic                                req_credit_o,
    output logic                                resp_valid_o,
    output logic [cache_pkg::DATA_WIDTH-1:0]    resp_rdata_o,
    output logic                                resp_hit_o
);

    // queue to controller
    logic                                   q_valid;
    cache_pkg::cache_op_e                   q_op;
    logic [cache_pkg::ADDR_WIDTH-1:0]       q_addr;
    logic [cache_pkg::DATA_WIDTH-1:0]       q_wdata;
    logic                                   q_pop;

    // controller to line store
    logic [cache_pkg::SET_WIDTH-1:0]        lookup_set;
    logic [cache_pkg::DATA_WIDTH-1:0]       line_data;
    logic [cache_pkg::TAG_WIDTH-1:0]        line_tag;
    logic                                   line_valid;
    logic                                   line_dirty;
    logic                                   upd_en;
    logic [cache_pkg::SET_WIDTH-1:0]        upd_set;
    logic [cache_pkg::DATA_WIDTH-1:0]       upd_data;
    logic [cache_pkg::TAG_WIDTH-1:0]        upd_tag;
    logic                                   upd_dirty;

    // controller to memory
    logic                                   mem_wen;
    logic [cache_pkg::WORD_ADDR_WIDTH-1:0]  mem_waddr;
    logic [cache_pkg::DATA_WIDTH-1:0]       mem_wdata;
    logic                                   mem_ren;
    logic [cache_pkg::WORD_ADDR_WIDTH-1:0]  mem_raddr;
    logic                                   mem_rvalid;
    logic [cache_pkg::DATA_WIDTH-1:0]       mem_rdata;

    cache_req_queue u_queue (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_valid_i  (req_valid_i),
        .req_op_i     (req_op_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .q_pop_i      (q_pop),
        .q_valid_o    (q_valid),
        .q_op_o       (q_op),
        .q_addr_o     (q_addr),
        .q_wdata_o    (q_wdata),
        .req_credit_o (req_credit_o)
    );

    cache_line_store u_lines (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .lookup_set_i (lookup_set),
        .line_data_o  (line_data),
        .line_tag_o   (line_tag),
        .line_valid_o (line_valid),
        .line_dirty_o (line_dirty),
        .upd_en_i     (upd_en),
        .upd_set_i    (upd_set),
        .upd_data_i   (upd_data),
        .upd_tag_i    (upd_tag),
        .upd_dirty_i  (upd_dirty)
    );

    direct_cache u_ctrl (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .q_valid_i    (q_valid),
        .q_op_i       (q_op),
        .q_addr_i     (q_addr),
        .q_wdata_i    (q_wdata),
        .q_pop_o      (q_pop),
        .lookup_set_o (lookup_set),
        .line_data_i  (line_data),
        .line_tag_i   (line_tag),
        .line_valid_i (line_valid),
        .line_dirty_i (line_dirty),
        .upd_en_o     (upd_en),
        .upd_set_o    (upd_set),
        .upd_data_o   (upd_data),
        .upd_tag_o    (upd_tag),
        .upd_dirty_o  (upd_dirty),
        .mem_wen_o    (mem_wen),
        .mem_waddr_o  (mem_waddr),
        .mem_wdata_o  (mem_wdata),
        .mem_ren_o    (mem_ren),
        .mem_raddr_o  (mem_raddr),
        .mem_rvalid_i (mem_rvalid),
        .mem_rdata_i  (mem_rdata),
        .resp_valid_o (resp_valid_o),
        .resp_rdata_o (resp_rdata_o),
        .resp_hit_o   (resp_hit_o)
    );

    data_memory u_mem (
        .clk_i    (clk_i),
        .wen_i    (mem_wen),
        .waddr_i  (mem_waddr),
        .wdata_i  (mem_wdata),
        .ren_i    (mem_ren),
        .raddr_i  (mem_raddr),
        .rvalid_o (mem_rvalid),
        .rdata_o  (mem_rdata)
    );

endmodule

// File: logic/data_memory.sv
// backing memory: word array, writes at the strobe edge, reads return after fixed latency
`timescale 1ns/1ps

module data_memory (
    input  logic                                    clk_i,
    input  logic                                    wen_i,
    input  logic [cache_pkg::WORD_ADDR_WIDTH-1:0]   waddr_i,
    input  logic [cache_pkg::DATA_WIDTH-1:0]        wdata_i,
    input  logic                                    ren_i,
    input  logic [cache_pkg::WORD_ADDR_WIDTH-1:0]   raddr_i,
    output logic                                    rvalid_o,
    output logic [cache_pkg::DATA_WIDTH-1:0]        rdata_o
);

    logic [cache_pkg::DATA_WIDTH-1:0] mem_q [cache_pkg::MEM_WORDS];

    // read pipeline, stage 0 samples the array
    logic [cache_pkg::MEM_READ_LATENCY-1:0] rvalid_sr;
    logic [cache_pkg::DATA_WIDTH-1:0]       rdata_sr [cache_pkg::MEM_READ_LATENCY];

    always_ff @(posedge clk_i) begin
        if (wen_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        rvalid_sr[0] <= ren_i;
        rdata_sr[0]  <= mem_q[raddr_i];
        for (int i = 1; i < cache_pkg::MEM_READ_LATENCY; i++) begin
            rvalid_sr[i] <= rvalid_sr[i-1];
            rdata_sr[i]  <= rdata_sr[i-1];
        end
    end

    assign rvalid_o = rvalid_sr[cache_pkg::MEM_READ_LATENCY-1];
    assign rdata_o  = rdata_sr[cache_pkg::MEM_READ_LATENCY-1];

endmodule

// File: logic/direct_cache.sv
// cache controller: FSM for lookup, dirty writeback, fill and in-order response
`timescale 1ns/1ps

module direct_cache (
    input  logic                                    clk_i,
    input  logic                                    rst_i,
    // request queue side
    input  logic                                    q_valid_i,
    input  cache_pkg::cache_op_e                    q_op_i,
    input  logic [cache_pkg::ADDR_WIDTH-1:0]        q_addr_i,
    input  logic [cache_pkg::DATA_WIDTH-1:0]        q_wdata_i,
    output logic                                    q_pop_o,
    // line store side
    output logic [cache_pkg::SET_WIDTH-1:0]         lookup_set_o,
    input  logic [cache_pkg::DATA_WIDTH-1:0]        line_data_i,
    input  logic [cache_pkg::TAG_WIDTH-1:0]         line_tag_i,
    input  logic                                    line_valid_i,
    input  logic                                    line_dirty_i,
    output logic                                    upd_en_o,
    output logic [cache_pkg::SET_WIDTH-1:0]         upd_set_o,
    output logic [cache_pkg::DATA_WIDTH-1:0]        upd_data_o,
    output logic [cache_pkg::TAG_WIDTH-1:0]         upd_tag_o,
    output logic                                    upd_dirty_o,
    // backing memory side
    output logic                                    mem_wen_o,
    output logic [cache_pkg::WORD_ADDR_WIDTH-1:0]   mem_waddr_o,
    output logic [cache_pkg::DATA_WIDTH-1:0]        mem_wdata_o,
    output logic                                    mem_ren_o,
    output logic [cache_pkg::WORD_ADDR_WIDTH-1:0]   mem_raddr_o,
    input  logic                                    mem_rvalid_i,
    input  logic [cache_pkg::DATA_WIDTH-1:0]        mem_rdata_i,
    // response side
    output logic                                    resp_valid_o,
    output logic [cache_pkg::DATA_WIDTH-1:0]        resp_rdata_o,
    output logic                                    resp_hit_o
);

    cache_pkg::ctrl_state_e state_q;
    cache_pkg::ctrl_state_e state_d;

    // request in service
    cache_pkg::cache_op_e              req_op_q;
    logic [cache_pkg::ADDR_WIDTH-1:0]  req_addr_q;
    logic [cache_pkg::DATA_WIDTH-1:0]  req_wdata_q;
    logic                              hit_q;

    logic [cache_pkg::SET_WIDTH-1:0]   req_set;
    logic [cache_pkg::TAG_WIDTH-1:0]   req_tag;
    logic                              is_write;
    logic                              tag_hit;
    logic                              victim_dirty;

    assign req_set = req_addr_q[cache_pkg::OFFSET_WIDTH +: cache_pkg::SET_WIDTH];
    assign req_tag = req_addr_q[cache_pkg::ADDR_WIDTH-1 -: cache_pkg::TAG_WIDTH];

    assign is_write     = (req_op_q == cache_pkg::OP_WRITE);
    assign tag_hit      = line_valid_i && (line_tag_i == req_tag);
    assign victim_dirty = line_valid_i && line_dirty_i;  // only matters on a miss

    assign q_pop_o      = (state_q == cache_pkg::ST_IDLE) && q_valid_i;
    assign lookup_set_o = req_set;

    // line install, always the requested tag and set
    assign upd_set_o   = req_set;
    assign upd_tag_o   = req_tag;
    assign upd_data_o  = is_write ? req_wdata_q : mem_rdata_i;
    assign upd_dirty_o = is_write;  // fills come in clean

    always_comb begin
        case (state_q)
            cache_pkg::ST_LOOKUP:    upd_en_o = is_write && (tag_hit || !victim_dirty);
            cache_pkg::ST_WRITEBACK: upd_en_o = is_write;  // victim leaves this cycle
            cache_pkg::ST_FILL_WAIT: upd_en_o = mem_rvalid_i;
            default:                 upd_en_o = 1'b0;
        endcase
    end

    // victim goes out at {old tag, set}, fill comes from {new tag, set}
    assign mem_wen_o   = (state_q == cache_pkg::ST_WRITEBACK);
    assign mem_waddr_o = {line_tag_i, req_set};
    assign mem_wdata_o = line_data_i;
    assign mem_ren_o   = (state_q == cache_pkg::ST_FILL_REQ);
    assign mem_raddr_o = {req_tag, req_set};

    // line already holds the answer by the time we respond
    assign resp_valid_o = (state_q == cache_pkg::ST_RESPOND);
    assign resp_rdata_o = line_data_i;
    assign resp_hit_o   = hit_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            cache_pkg::ST_IDLE: begin
                if (q_valid_i) begin
                    state_d = cache_pkg::ST_LOOKUP;
                end
            end
            cache_pkg::ST_LOOKUP: begin
                if (tag_hit) begin
                    state_d = cache_pkg::ST_RESPOND;
                end else if (victim_dirty) begin
                    state_d = cache_pkg::ST_WRITEBACK;
                end else if (is_write) begin
                    state_d = cache_pkg::ST_RESPOND;  // allocate, no fill needed
                end else begin
                    state_d = cache_pkg::ST_FILL_REQ;
                end
            end
            cache_pkg::ST_WRITEBACK: begin
                state_d = is_write ? cache_pkg::ST_RESPOND : cache_pkg::ST_FILL_REQ;
            end
            cache_pkg::ST_FILL_REQ:  state_d = cache_pkg::ST_FILL_WAIT;
            cache_pkg::ST_FILL_WAIT: begin
                if (mem_rvalid_i) begin
                    state_d = cache_pkg::ST_RESPOND;
                end
            end
            cache_pkg::ST_RESPOND:   state_d = cache_pkg::ST_IDLE;
            default:                 state_d = cache_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= cache_pkg::ST_IDLE;
            hit_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == cache_pkg::ST_LOOKUP) begin
                hit_q <= tag_hit;
            end
        end
    end

    // capture popped request
    always_ff @(posedge clk_i) begin
        if (q_pop_o) begin
            req_op_q    <= q_op_i;
            req_addr_q  <= q_addr_i;
            req_wdata_q <= q_wdata_i;
        end
    end

endmodule

// File: logic/cache_line_store.sv
// cache line store: 8 one-word lines with tag and flags, combinational lookup, registered update
`timescale 1ns/1ps

module cache_line_store (
    input  logic                                clk_i,
    input  logic                                rst_i,
    // lookup port
    input  logic [cache_pkg::SET_WIDTH-1:0]     lookup_set_i,
    output logic [cache_pkg::DATA_WIDTH-1:0]    line_data_o,
    output logic [cache_pkg::TAG_WIDTH-1:0]     line_tag_o,
    output logic                                line_valid_o,
    output logic                                line_dirty_o,
    // update port
    input  logic                                upd_en_i,
    input  logic [cache_pkg::SET_WIDTH-1:0]     upd_set_i,
    input  logic [cache_pkg::DATA_WIDTH-1:0]    upd_data_i,
    input  logic [cache_pkg::TAG_WIDTH-1:0]     upd_tag_i,
    input  logic                                upd_dirty_i
);

    logic [cache_pkg::DATA_WIDTH-1:0] data_mem [cache_pkg::NUM_SETS];
    logic [cache_pkg::TAG_WIDTH-1:0]  tag_mem  [cache_pkg::NUM_SETS];
    logic [cache_pkg::NUM_SETS-1:0]   valid_q;
    logic [cache_pkg::NUM_SETS-1:0]   dirty_q;

    // lookup is plain array read, same cycle
    assign line_data_o  = data_mem[lookup_set_i];
    assign line_tag_o   = tag_mem[lookup_set_i];
    assign line_valid_o = valid_q[lookup_set_i];
    assign line_dirty_o = dirty_q[lookup_set_i];

    // data and tag, whole line at once
    always_ff @(posedge clk_i) begin
        if (upd_en_i) begin
            data_mem[upd_set_i] <= upd_data_i;
            tag_mem[upd_set_i]  <= upd_tag_i;
        end
    end

    // flags, reset invalidates all lines
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (upd_en_i) begin
            valid_q[upd_set_i] <= 1'b1;  // any install makes the line valid
            dirty_q[upd_set_i] <= upd_dirty_i;
        end
    end

endmodule

// File: logic/cache_req_queue.sv
// request queue: circular buffer of pending requests, returns one credit per pop
`timescale 1ns/1ps

module cache_req_queue (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                req_valid_i,
    input  cache_pkg::cache_op_e                req_op_i,
    input  logic [cache_pkg::ADDR_WIDTH-1:0]    req_addr_i,
    input  logic [cache_pkg::DATA_WIDTH-1:0]    req_wdata_i,
    input  logic                                q_pop_i,
    output logic                                q_valid_o,
    output cache_pkg::cache_op_e                q_op_o,
    output logic [cache_pkg::ADDR_WIDTH-1:0]    q_addr_o,
    output logic [cache_pkg::DATA_WIDTH-1:0]    q_wdata_o,
    output logic                                req_credit_o
);

    cache_pkg::cache_op_e                op_mem    [cache_pkg::REQ_QUEUE_DEPTH];
    logic [cache_pkg::ADDR_WIDTH-1:0]    addr_mem  [cache_pkg::REQ_QUEUE_DEPTH];
    logic [cache_pkg::DATA_WIDTH-1:0]    wdata_mem [cache_pkg::REQ_QUEUE_DEPTH];

    logic [cache_pkg::QPTR_WIDTH-1:0] wr_ptr_q;
    logic [cache_pkg::QPTR_WIDTH-1:0] rd_ptr_q;
    logic [cache_pkg::QCNT_WIDTH-1:0] count_q;
    logic                             push;
    logic                             pop;

    function automatic logic [cache_pkg::QPTR_WIDTH-1:0] ptr_next(
        input logic [cache_pkg::QPTR_WIDTH-1:0] ptr
    );
        if (ptr == cache_pkg::QPTR_LAST) begin
            return '0;  // wrap
        end
        return ptr + 1'b1;
    endfunction

    assign push = req_valid_i;  // credit flow guarantees room
    assign pop  = q_pop_i && q_valid_o;

    assign q_valid_o    = (count_q != '0);
    assign q_op_o       = op_mem[rd_ptr_q];
    assign q_addr_o     = addr_mem[rd_ptr_q];
    assign q_wdata_o    = wdata_mem[rd_ptr_q];
    assign req_credit_o = pop;  // one credit back per request taken

    // payload storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            op_mem[wr_ptr_q]    <= req_op_i;
            addr_mem[wr_ptr_q]  <= req_addr_i;
            wdata_mem[wr_ptr_q] <= req_wdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // none, or push and pop together
            endcase
        end
    end

endmodule

// File: logic/cache_pkg.sv
// cache package: address split widths, queue and memory timing, operation and state enums
package cache_pkg;

    // request address and data
    localparam int ADDR_WIDTH   = 16;
    localparam int DATA_WIDTH   = 32;

    // byte address = {tag, set, offset}
    localparam int OFFSET_WIDTH = 2;  // ignored, word access only
    localparam int SET_WIDTH    = 3;
    localparam int NUM_SETS     = 2 ** SET_WIDTH;
    localparam int TAG_WIDTH    = ADDR_WIDTH - SET_WIDTH - OFFSET_WIDTH;

    // backing memory is word addressed by {tag, set}
    localparam int WORD_ADDR_WIDTH = ADDR_WIDTH - OFFSET_WIDTH;
    localparam int MEM_WORDS       = 2 ** WORD_ADDR_WIDTH;
    localparam int MEM_READ_LATENCY = 2;  // strobe to data valid

    // request queue, depth is also the credit count after reset
    localparam int REQ_QUEUE_DEPTH = 2;
    localparam int QPTR_WIDTH      = (REQ_QUEUE_DEPTH > 1) ? $clog2(REQ_QUEUE_DEPTH) : 1;
    localparam int QCNT_WIDTH      = $clog2(REQ_QUEUE_DEPTH + 1);
    localparam logic [QPTR_WIDTH-1:0] QPTR_LAST = QPTR_WIDTH'(REQ_QUEUE_DEPTH - 1);

    // request operation
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cache_op_e;

    // controller FSM
    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,  // wait for a queued request
        ST_LOOKUP    = 3'd1,  // tag compare, hit or miss decision
        ST_WRITEBACK = 3'd2,  // dirty victim to memory
        ST_FILL_REQ  = 3'd3,  // read strobe to memory
        ST_FILL_WAIT = 3'd4,  // wait for read data
        ST_RESPOND   = 3'd5   // one-cycle response
    } ctrl_state_e;

endpackage
